// ==== logic/ar_channel_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module ar_channel_mux
(
    input  wire                              clk_i,
    input  wire                              rst_i,

    // Upstream masters
    input  wire axi_rd_arb_pkg::port_mask_t  inport_arvalid_i,
    input  wire axi_rd_arb_pkg::addr_t
                [axi_rd_arb_pkg::NUM_PORTS-1:0] inport_araddr_i,
    input  wire axi_rd_arb_pkg::id_t
                [axi_rd_arb_pkg::NUM_PORTS-1:0] inport_arid_i,
    input  wire axi_rd_arb_pkg::len_t
                [axi_rd_arb_pkg::NUM_PORTS-1:0] inport_arlen_i,
    input  wire axi_rd_arb_pkg::burst_e
                [axi_rd_arb_pkg::NUM_PORTS-1:0] inport_arburst_i,
    output axi_rd_arb_pkg::port_mask_t       inport_arready_o,

    // Downstream port
    output logic                             outport_arvalid_o,
    output axi_rd_arb_pkg::addr_t            outport_araddr_o,
    output axi_rd_arb_pkg::id_t              outport_arid_o,
    output axi_rd_arb_pkg::len_t             outport_arlen_o,
    output axi_rd_arb_pkg::burst_e           outport_arburst_o,
    input  wire                              outport_arready_i
);

    import axi_rd_arb_pkg::*;

    ar_state_e  state_q;
    logic       hold_w;
    port_mask_t grant_w;

    // ------------------------------
    // Grant hold
    // ------------------------------
    // Stalled offer freezes the grant until the slave accepts
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            state_q <= AR_OPEN;
        end
        else if (outport_arvalid_o && !outport_arready_i)
        begin
            state_q <= AR_HOLD;
        end
        else if (outport_arready_i)
        begin
            state_q <= AR_OPEN;
        end
    end

    assign hold_w = (state_q == AR_HOLD);

    rr_arbiter u_arb
    (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .hold_i    (hold_w),
        .request_i (inport_arvalid_i),
        .grant_o   (grant_w)
    );

    // ------------------------------
    // Field select
    // ------------------------------
    // Port 0 is shown when nothing is granted
    always_comb
    begin
        outport_arvalid_o = inport_arvalid_i[0];
        outport_araddr_o  = inport_araddr_i[0];
        outport_arid_o    = inport_arid_i[0];
        outport_arlen_o   = inport_arlen_i[0];
        outport_arburst_o = inport_arburst_i[0];

        for (int i = 1; i < NUM_PORTS; i++)
        begin
            if (grant_w[i])
            begin
                outport_arvalid_o = inport_arvalid_i[i];
                outport_araddr_o  = inport_araddr_i[i];
                outport_arid_o    = inport_arid_i[i];
                outport_arlen_o   = inport_arlen_i[i];
                outport_arburst_o = inport_arburst_i[i];
            end
        end
    end

    // Ready goes back to the granted master only
    assign inport_arready_o = grant_w & {NUM_PORTS{outport_arready_i}};

    // ------------------------------
    // Checks
    // ------------------------------
    // A stalled request may not be withdrawn by its master
    assert property (@(posedge clk_i) disable iff (rst_i)
                     hold_w |-> outport_arvalid_o)
        else $error("ar_channel_mux: arvalid dropped while held");

    // Held request keeps its address and ID
    assert property (@(posedge clk_i) disable iff (rst_i)
                     hold_w |-> ($stable(outport_araddr_o) && $stable(outport_arid_o)))
        else $error("ar_channel_mux: AR fields changed while held");

endmodule

`default_nettype wire

// ==== logic/axi_rd_arb.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_rd_arb
(
    input  wire                              clk_i,
    input  wire                              rst_i,

    // ------------------------------
    // Upstream AR
    // ------------------------------
    input  wire axi_rd_arb_pkg::port_mask_t  inport_arvalid_i,
    input  wire axi_rd_arb_pkg::addr_t
                [axi_rd_arb_pkg::NUM_PORTS-1:0] inport_araddr_i,
    input  wire axi_rd_arb_pkg::id_t
                [axi_rd_arb_pkg::NUM_PORTS-1:0] inport_arid_i,
    input  wire axi_rd_arb_pkg::len_t
                [axi_rd_arb_pkg::NUM_PORTS-1:0] inport_arlen_i,
    input  wire axi_rd_arb_pkg::burst_e
                [axi_rd_arb_pkg::NUM_PORTS-1:0] inport_arburst_i,
    output axi_rd_arb_pkg::port_mask_t       inport_arready_o,

    // Upstream R
    output axi_rd_arb_pkg::port_mask_t       inport_rvalid_o,
    output axi_rd_arb_pkg::data_t
           [axi_rd_arb_pkg::NUM_PORTS-1:0]   inport_rdata_o,
    output axi_rd_arb_pkg::resp_t
           [axi_rd_arb_pkg::NUM_PORTS-1:0]   inport_rresp_o,
    output axi_rd_arb_pkg::id_t
           [axi_rd_arb_pkg::NUM_PORTS-1:0]   inport_rid_o,
    output logic [axi_rd_arb_pkg::NUM_PORTS-1:0] inport_rlast_o,
    input  wire axi_rd_arb_pkg::port_mask_t  inport_rready_i,

    // ------------------------------
    // Downstream AR and R
    // ------------------------------
    output logic                             outport_arvalid_o,
    output axi_rd_arb_pkg::addr_t            outport_araddr_o,
    output axi_rd_arb_pkg::id_t              outport_arid_o,
    output axi_rd_arb_pkg::len_t             outport_arlen_o,
    output axi_rd_arb_pkg::burst_e           outport_arburst_o,
    input  wire                              outport_arready_i,

    input  wire                              outport_rvalid_i,
    input  wire axi_rd_arb_pkg::data_t       outport_rdata_i,
    input  wire axi_rd_arb_pkg::resp_t       outport_rresp_i,
    input  wire axi_rd_arb_pkg::id_t         outport_rid_i,
    input  wire                              outport_rlast_i,
    output logic                             outport_rready_o
);

    // Request path with arbitration
    ar_channel_mux u_ar_mux
    (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .inport_arvalid_i  (inport_arvalid_i),
        .inport_araddr_i   (inport_araddr_i),
        .inport_arid_i     (inport_arid_i),
        .inport_arlen_i    (inport_arlen_i),
        .inport_arburst_i  (inport_arburst_i),
        .inport_arready_o  (inport_arready_o),
        .outport_arvalid_o (outport_arvalid_o),
        .outport_araddr_o  (outport_araddr_o),
        .outport_arid_o    (outport_arid_o),
        .outport_arlen_o   (outport_arlen_o),
        .outport_arburst_o (outport_arburst_o),
        .outport_arready_i (outport_arready_i)
    );

    // Response path, routed by ID
    r_channel_router u_r_router
    (
        .outport_rvalid_i  (outport_rvalid_i),
        .outport_rdata_i   (outport_rdata_i),
        .outport_rresp_i   (outport_rresp_i),
        .outport_rid_i     (outport_rid_i),
        .outport_rlast_i   (outport_rlast_i),
        .outport_rready_o  (outport_rready_o),
        .inport_rvalid_o   (inport_rvalid_o),
        .inport_rdata_o    (inport_rdata_o),
        .inport_rresp_o    (inport_rresp_o),
        .inport_rid_o      (inport_rid_o),
        .inport_rlast_o    (inport_rlast_o),
        .inport_rready_i   (inport_rready_i)
    );

endmodule

`default_nettype wire

// ==== logic/axi_rd_arb_pkg.sv ====
`default_nettype none

package axi_rd_arb_pkg;

    // ------------------------------
    // Port count and selection
    // ------------------------------
    localparam int NUM_PORTS  = 4;

    // Upper ID bits carry the issuing port index
    localparam int PORT_SEL_W = 2;

    // ------------------------------
    // AXI field widths
    // ------------------------------
    localparam int ADDR_W  = 32;
    localparam int DATA_W  = 32;
    localparam int ID_W    = 4;
    localparam int LEN_W   = 8;
    localparam int BURST_W = 2;
    localparam int RESP_W  = 2;

    // One bit per upstream master
    typedef logic [NUM_PORTS-1:0] port_mask_t;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ID_W-1:0]   id_t;
    typedef logic [LEN_W-1:0]  len_t;
    typedef logic [RESP_W-1:0] resp_t;

    // AXI4 burst encodings
    typedef enum logic [BURST_W-1:0]
    {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } burst_e;

    // AR path
    // open lets the arbiter pick again, hold freezes the grant
    typedef enum logic
    {
        AR_OPEN = 1'b0,
        AR_HOLD = 1'b1
    } ar_state_e;

endpackage

`default_nettype wire

// ==== logic/r_channel_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module r_channel_router
(
    // Downstream port
    input  wire                               outport_rvalid_i,
    input  wire axi_rd_arb_pkg::data_t        outport_rdata_i,
    input  wire axi_rd_arb_pkg::resp_t        outport_rresp_i,
    input  wire axi_rd_arb_pkg::id_t          outport_rid_i,
    input  wire                               outport_rlast_i,
    output logic                              outport_rready_o,

    // Upstream masters
    output axi_rd_arb_pkg::port_mask_t        inport_rvalid_o,
    output axi_rd_arb_pkg::data_t
           [axi_rd_arb_pkg::NUM_PORTS-1:0]    inport_rdata_o,
    output axi_rd_arb_pkg::resp_t
           [axi_rd_arb_pkg::NUM_PORTS-1:0]    inport_rresp_o,
    output axi_rd_arb_pkg::id_t
           [axi_rd_arb_pkg::NUM_PORTS-1:0]    inport_rid_o,
    output logic [axi_rd_arb_pkg::NUM_PORTS-1:0] inport_rlast_o,
    input  wire axi_rd_arb_pkg::port_mask_t   inport_rready_i
);

    import axi_rd_arb_pkg::*;

    logic [PORT_SEL_W-1:0] port_sel_w;
    port_mask_t            target_w;

    // ------------------------------
    // Destination decode
    // ------------------------------
    // Top ID bits name the master that issued the read
    assign port_sel_w = outport_rid_i[ID_W-1 -: PORT_SEL_W];

    always_comb
    begin
        target_w             = '0;
        target_w[port_sel_w] = 1'b1;
    end

    // ------------------------------
    // Beat steering
    // ------------------------------
    assign inport_rvalid_o = target_w & {NUM_PORTS{outport_rvalid_i}};

    // Payload is broadcast, only valid is qualified
    assign inport_rdata_o = {NUM_PORTS{outport_rdata_i}};
    assign inport_rresp_o = {NUM_PORTS{outport_rresp_i}};
    assign inport_rid_o   = {NUM_PORTS{outport_rid_i}};
    assign inport_rlast_o = {NUM_PORTS{outport_rlast_i}};

    // Back-pressure comes from the addressed master alone
    assign outport_rready_o = |(inport_rready_i & target_w);

    // At most one master sees a beat
    always_comb
    begin
        assert ($onehot0(inport_rvalid_o))
            else $error("r_channel_router: rvalid routed to several ports");
    end

endmodule

`default_nettype wire

// ==== logic/rr_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter
(
    input  wire                        clk_i,
    input  wire                        rst_i,
    input  wire                        hold_i,
    input  wire axi_rd_arb_pkg::port_mask_t request_i,
    output axi_rd_arb_pkg::port_mask_t grant_o
);

    import axi_rd_arb_pkg::*;

    port_mask_t mask_q;
    port_mask_t grant_last_q;
    port_mask_t thermo_masked_w;
    port_mask_t thermo_all_w;
    port_mask_t thermo_w;
    port_mask_t grant_new_w;

    // Thermometer code, set from the lowest request upward
    function automatic port_mask_t ffs_thermo(input port_mask_t req);
        port_mask_t res;
        res[0] = req[0];
        for (int i = 1; i < NUM_PORTS; i++)
        begin
            res[i] = res[i-1] | req[i];
        end
        return res;
    endfunction

    // ------------------------------
    // Priority selection
    // ------------------------------
    assign thermo_masked_w = ffs_thermo(request_i & mask_q);
    assign thermo_all_w    = ffs_thermo(request_i);

    // Wrap to the lowest requester when nothing above the last winner asks
    assign thermo_w = (|thermo_masked_w) ? thermo_masked_w : thermo_all_w;

    // Edge of the thermometer code gives the one-hot pick
    assign grant_new_w = thermo_w ^ (thermo_w << 1);

    assign grant_o = hold_i ? grant_last_q : grant_new_w;

    // ------------------------------
    // Mask and last grant
    // ------------------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            mask_q       <= '1;
            grant_last_q <= '0;
        end
        else
        begin
            // Only ports above this pick stay eligible first
            if (!hold_i)
            begin
                mask_q <= thermo_w << 1;
            end
            grant_last_q <= grant_o;
        end
    end

    // Never more than one master owns the downstream port
    assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(grant_o))
        else $error("rr_arbiter: grant is not one-hot");

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run the testbench and look for the pass line
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f vlog.f --top-module tb_axi_rd_arb \
        -o tb_axi_rd_arb \
    && ./obj_dir/tb_axi_rd_arb | tee /dev/stderr | grep -qx "Regression passed" \
    && echo "run.sh: simulation ok" \
    || { echo "run.sh: simulation not ok"; exit 1; }

// ==== verif/tb_axi_rd_arb.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_axi_rd_arb;

    import axi_rd_arb_pkg::*;

    localparam int          CLK_PERIOD    = 4;
    localparam logic [31:0] LCG_SEED      = 32'hae03b71a;
    localparam int          RESET_CYCLES  = 3;
    localparam int          ROT_CYCLES    = 16;
    localparam int          SPARSE_CYCLES = 40;
    localparam int          STALL_CYCLES  = 5;
    localparam int          DRAIN_CYCLES  = 6;
    localparam int          RANDOM_CYCLES = 400;
    // Single master, routing and idle steps
    localparam int          FIXED_CYCLES  = 60;
    localparam int          TOTAL_CYCLES  = RESET_CYCLES + ROT_CYCLES + SPARSE_CYCLES
                                          + STALL_CYCLES + 3 * DRAIN_CYCLES
                                          + RANDOM_CYCLES + FIXED_CYCLES;

    logic                   clk_i = 1'b0;
    logic                   rst_i;
    port_mask_t             inport_arvalid_i;
    addr_t  [NUM_PORTS-1:0] inport_araddr_i;
    id_t    [NUM_PORTS-1:0] inport_arid_i;
    len_t   [NUM_PORTS-1:0] inport_arlen_i;
    burst_e [NUM_PORTS-1:0] inport_arburst_i;
    port_mask_t             inport_arready_o;
    port_mask_t             inport_rvalid_o;
    data_t  [NUM_PORTS-1:0] inport_rdata_o;
    resp_t  [NUM_PORTS-1:0] inport_rresp_o;
    id_t    [NUM_PORTS-1:0] inport_rid_o;
    logic   [NUM_PORTS-1:0] inport_rlast_o;
    port_mask_t             inport_rready_i;
    logic                   outport_arvalid_o;
    addr_t                  outport_araddr_o;
    id_t                    outport_arid_o;
    len_t                   outport_arlen_o;
    burst_e                 outport_arburst_o;
    logic                   outport_arready_i;
    logic                   outport_rvalid_i;
    data_t                  outport_rdata_i;
    resp_t                  outport_rresp_i;
    id_t                    outport_rid_i;
    logic                   outport_rlast_i;
    logic                   outport_rready_o;

    // Model state and test bookkeeping
    logic [31:0] lcg_state = LCG_SEED;
    string       test_name;
    logic        rot_check;
    int          rot_next;
    port_mask_t  m_mask;
    port_mask_t  m_last;
    logic        m_hold;

    axi_rd_arb i_dut (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic burst_e pick_burst(input logic [1:0] r);
        case (r)
            2'd0:    return FIXED;
            2'd1:    return INCR;
            default: return WRAP;
        endcase
    endfunction

    // Lowest eligible requester above the last winner wins, else the lowest overall
    function automatic port_mask_t expected_grant(input port_mask_t req, input logic hold,
                                                  input port_mask_t mask,
                                                  input port_mask_t last,
                                                  output port_mask_t next_mask);
        port_mask_t g;
        int         pick;
        g         = '0;
        pick      = -1;
        next_mask = mask;
        if (hold)
            return last;
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            if (pick < 0 && req[i] && mask[i])
                pick = i;
        end
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            if (pick < 0 && req[i])
                pick = i;
        end
        // No requester leaves every port ineligible, so the lowest wins next
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            g[i]         = (i == pick);
            next_mask[i] = (pick >= 0) && (i > pick);
        end
        return g;
    endfunction

    task automatic check_value(input string field, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("error %s %s expected %h actual %h", test_name, field, expected, actual);
            $display("Regression failed");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic new_request(input int p);
        logic [31:0] r;
        r = lcg_next();
        inport_arvalid_i[p] <= 1'b1;
        inport_araddr_i[p]  <= lcg_next();
        inport_arid_i[p]    <= {PORT_SEL_W'(p), r[1:0]};
        inport_arlen_i[p]   <= r[15:8];
        inport_arburst_i[p] <= pick_burst(r[17:16]);
    endtask

    // Masters keep a request until it is accepted; rate is out of 256
    task automatic run_requests(input int cycles, input int rate, input logic random_ready,
                                input logic random_r);
        port_mask_t  accepted;
        logic [31:0] r;
        for (int c = 0; c < cycles; c++)
        begin
            @(negedge clk_i);
            accepted = inport_arvalid_i & inport_arready_o;
            @(posedge clk_i);
            for (int p = 0; p < NUM_PORTS; p++)
            begin
                if (!inport_arvalid_i[p] || accepted[p])
                begin
                    r = lcg_next();
                    if (int'(r[31:24]) < rate)
                        new_request(p);
                    else
                        inport_arvalid_i[p] <= 1'b0;
                end
            end
            r = lcg_next();
            outport_arready_i <= random_ready ? r[31] : 1'b1;
            outport_rvalid_i  <= random_r & r[30];
            outport_rlast_i   <= r[29];
            outport_rid_i     <= r[23:20];
            outport_rresp_i   <= r[17:16];
            inport_rready_i   <= r[27:24];
            outport_rdata_i   <= lcg_next();
        end
    endtask

    // ------------------------------
    // Compare against the model
    // ------------------------------
    always @(negedge clk_i)
    begin : compare
        port_mask_t grant;
        port_mask_t next_mask;
        port_mask_t exp_rvalid;
        port_mask_t accepted;
        int         sel;
        int         tgt;
        logic       exp_valid;
        if (rst_i)
        begin
            m_mask   = '1;
            m_last   = '0;
            m_hold   = 1'b0;
            rot_next = 0;
        end
        else
        begin
            grant = expected_grant(inport_arvalid_i, m_hold, m_mask, m_last, next_mask);
            sel   = 0;
            for (int p = 0; p < NUM_PORTS; p++)
            begin
                if (grant[p])
                    sel = p;
            end
            exp_valid = inport_arvalid_i[sel];
            check_value("arvalid", 32'(exp_valid), 32'(outport_arvalid_o));
            check_value("araddr", inport_araddr_i[sel], outport_araddr_o);
            check_value("arid", 32'(inport_arid_i[sel]), 32'(outport_arid_o));
            check_value("arlen", 32'(inport_arlen_i[sel]), 32'(outport_arlen_o));
            check_value("arburst", 32'(inport_arburst_i[sel]), 32'(outport_arburst_o));
            check_value("arready", 32'(grant & {NUM_PORTS{outport_arready_i}}),
                        32'(inport_arready_o));

            // R beats go to the port named by the top ID bits
            tgt             = int'(outport_rid_i[ID_W-1 -: PORT_SEL_W]);
            exp_rvalid      = '0;
            exp_rvalid[tgt] = outport_rvalid_i;
            check_value("rvalid", 32'(exp_rvalid), 32'(inport_rvalid_o));
            check_value("rready", 32'(inport_rready_i[tgt]), 32'(outport_rready_o));
            for (int p = 0; p < NUM_PORTS; p++)
            begin
                check_value("rdata", outport_rdata_i, inport_rdata_o[p]);
                check_value("rresp", 32'(outport_rresp_i), 32'(inport_rresp_o[p]));
                check_value("rid", 32'(outport_rid_i), 32'(inport_rid_o[p]));
                check_value("rlast", 32'(outport_rlast_i), 32'(inport_rlast_o[p]));
            end

            // Rotation follows the ports the DUT actually accepts
            accepted = inport_arvalid_i & inport_arready_o;
            if (!rot_check)
                rot_next = 0;
            else if (|accepted)
            begin
                check_value("rotation port", 32'(port_mask_t'(1 << rot_next)),
                            32'(accepted));
                rot_next = (rot_next + 1) % NUM_PORTS;
            end

            // Hold follows a stalled offer, release follows acceptance
            m_mask = next_mask;
            m_last = grant;
            if (exp_valid && !outport_arready_i)
                m_hold = 1'b1;
            else if (outport_arready_i)
                m_hold = 1'b0;
        end
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial
    begin : stimulus
        logic [31:0] r;
        test_name = "reset";
        rot_check = 1'b0;
        rst_i             <= 1'b1;
        inport_arvalid_i  <= '0;
        inport_araddr_i   <= '0;
        inport_arid_i     <= '0;
        inport_arlen_i    <= '0;
        inport_rready_i   <= '0;
        outport_arready_i <= 1'b0;
        outport_rvalid_i  <= 1'b0;
        outport_rdata_i   <= '0;
        outport_rresp_i   <= '0;
        outport_rid_i     <= '0;
        outport_rlast_i   <= 1'b0;
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            inport_arburst_i[p] <= INCR;
        end
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_i <= 1'b0;

        test_name = "single";
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            @(posedge clk_i);
            new_request(p);
            outport_arready_i <= 1'b1;
            @(negedge clk_i);
            check_value("own arready", 32'(port_mask_t'(1 << p)), 32'(inport_arready_o));
            @(posedge clk_i);
            inport_arvalid_i[p] <= 1'b0;
        end

        // An idle cycle first, so the rotation starts at port 0
        test_name = "rotation";
        run_requests(1, 0, 1'b0, 1'b0);
        rot_check = 1'b1;
        run_requests(ROT_CYCLES, 256, 1'b0, 1'b0);
        rot_check = 1'b0;
        test_name = "sparse";
        run_requests(SPARSE_CYCLES, 80, 1'b0, 1'b0);

        test_name = "backpressure";
        run_requests(DRAIN_CYCLES, 0, 1'b0, 1'b0);
        @(posedge clk_i);
        new_request(2);
        outport_arready_i <= 1'b0;
        @(posedge clk_i);
        new_request(0);
        new_request(1);
        new_request(3);
        repeat (STALL_CYCLES)
        begin
            @(negedge clk_i);
            check_value("held arvalid", 32'd1, 32'(outport_arvalid_o));
            check_value("held araddr", inport_araddr_i[2], outport_araddr_o);
            @(posedge clk_i);
        end
        outport_arready_i <= 1'b1;
        run_requests(DRAIN_CYCLES, 0, 1'b0, 1'b0);

        test_name = "routing";
        for (int t = 0; t < NUM_PORTS; t++)
        begin
            for (int k = 0; k < 4; k++)
            begin
                @(posedge clk_i);
                r = lcg_next();
                outport_rvalid_i <= k[0];
                outport_rid_i    <= {PORT_SEL_W'(t), r[1:0]};
                outport_rdata_i  <= lcg_next();
                outport_rresp_i  <= r[3:2];
                outport_rlast_i  <= r[4];
                // Target ready alone, then every port but the target
                inport_rready_i  <= k[1] ? port_mask_t'(1 << t) : ~port_mask_t'(1 << t);
            end
        end
        @(posedge clk_i);
        outport_rvalid_i <= 1'b0;

        test_name = "random";
        run_requests(RANDOM_CYCLES, 96, 1'b1, 1'b1);

        @(negedge clk_i);
        @(posedge clk_i);
        $display("Regression passed");
        $finish;
    end

    // Watchdog
    initial
    begin
        #(TOTAL_CYCLES * CLK_PERIOD * 2);
        $display("Timeout: tests did not finish within %0d cycles", TOTAL_CYCLES * 2);
        $display("Regression failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/axi_rd_arb_pkg.sv
logic/rr_arbiter.sv
logic/ar_channel_mux.sv
logic/r_channel_router.sv
logic/axi_rd_arb.sv
verif/tb_axi_rd_arb.sv
